//--- include/tinymips_config.svh
// core parameters; widths follow MIPS32, so only the reset PC is safe to change
`ifndef TINYMIPS_CONFIG_SVH
`define TINYMIPS_CONFIG_SVH

// register and data width
`define TM_DATA_W     32
`define TM_REG_NUM    32
`define TM_REG_ADDR_W 5

// fetch
`define TM_RESET_PC   32'hbfc0_0000
`define TM_PC_STEP    32'd4

`endif

//--- design/tinymips_pkg.sv
// shared types; only R-type ALU ops and the listed immediate ops have codes here
package tinymips_pkg;

        typedef enum logic [3:0] {
                ALU_NOP,
                ALU_ADDU,
                ALU_SUBU,
                ALU_AND,
                ALU_OR,
                ALU_XOR,
                ALU_NOR,
                ALU_SLT,
                ALU_SLTU,
                ALU_LUI
        } alu_op_e;

        typedef enum logic [5:0] {
                OP_SPECIAL = 6'h00,
                OP_ADDIU   = 6'h09,
                OP_SLTI    = 6'h0a,
                OP_ANDI    = 6'h0c,
                OP_ORI     = 6'h0d,
                OP_XORI    = 6'h0e,
                OP_LUI     = 6'h0f
        } opcode_e;

        typedef enum logic [5:0] {
                F_ADDU = 6'h21,
                F_SUBU = 6'h23,
                F_AND  = 6'h24,
                F_OR   = 6'h25,
                F_XOR  = 6'h26,
                F_NOR  = 6'h27,
                F_SLT  = 6'h2a,
                F_SLTU = 6'h2b
        } funct_e;

        typedef struct packed {
                opcode_e     opcode;
                logic [4:0]  rs;
                logic [4:0]  rt;
                logic [4:0]  rd;
                logic [4:0]  shamt;
                funct_e      funct;
        } r_fmt_t;

        typedef struct packed {
                opcode_e     opcode;
                logic [4:0]  rs;
                logic [4:0]  rt;
                logic [15:0] imm16;
        } i_fmt_t;

        // same word, read as R or I format
        typedef union packed {
                r_fmt_t r;
                i_fmt_t i;
        } instr_u;

endpackage

//--- design/decode_bus_if.sv
// decode to execute bus; no handshake, valid every cycle, bubble means wreg low
`timescale 1ns/1ps
`include "tinymips_config.svh"

interface decode_bus_if import tinymips_pkg::*; ();

        alu_op_e                   aluop;
        logic [`TM_DATA_W-1:0]     opnd_a;
        logic [`TM_DATA_W-1:0]     opnd_b;
        logic [`TM_REG_ADDR_W-1:0] wd;
        logic                      wreg;

        modport src (
                output aluop, opnd_a, opnd_b, wd, wreg
        );

        modport dst (
                input aluop, opnd_a, opnd_b, wd, wreg
        );

endinterface

//--- design/fetch_unit.sv
// ROM must answer combinationally; the PC advances every cycle, no stall or branch
`timescale 1ns/1ps
`include "tinymips_config.svh"

module fetch_unit import tinymips_pkg::*; (
        input  logic                  clk,
        input  logic                  rst_n_i,
        input  logic [`TM_DATA_W-1:0] rom_data_i,
        output logic [`TM_DATA_W-1:0] rom_addr_o,
        output logic                  rom_ce_o,
        output instr_u                id_inst_o,
        output logic [`TM_DATA_W-1:0] id_pc_o
);

        logic [`TM_DATA_W-1:0] pc_q;
        logic                  ce_q;

        // pc holds the reset vector until the first enabled cycle
        always_ff @(posedge clk)
        begin
                if (!rst_n_i)
                begin
                        pc_q <= `TM_RESET_PC;
                        ce_q <= 1'b0;
                end
                else
                begin
                        ce_q <= 1'b1;
                        if (ce_q)
                                pc_q <= pc_q + `TM_PC_STEP;
                end
        end

        // IF/ID; a zero word is a nop
        always_ff @(posedge clk)
        begin
                if (!rst_n_i || !ce_q)
                        id_inst_o <= '0;
                else
                        id_inst_o <= rom_data_i;
                id_pc_o <= pc_q;
        end

        assign rom_addr_o = pc_q;
        assign rom_ce_o   = ce_q;

        a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
                pc_q[1:0] == 2'b00);

endmodule

//--- design/decoder.sv
// unsupported words become nops; operands forward from EX, then MEM, then regfile
`timescale 1ns/1ps
`include "tinymips_config.svh"

module decoder import tinymips_pkg::*; (
        input  instr_u                    id_inst_i,
        input  logic [`TM_DATA_W-1:0]     id_pc_i,
        output logic [`TM_REG_ADDR_W-1:0] reg1_addr_o,
        output logic [`TM_REG_ADDR_W-1:0] reg2_addr_o,
        input  logic [`TM_DATA_W-1:0]     reg1_data_i,
        input  logic [`TM_DATA_W-1:0]     reg2_data_i,
        input  logic                      ex_wreg_i,
        input  logic [`TM_REG_ADDR_W-1:0] ex_wd_i,
        input  logic [`TM_DATA_W-1:0]     ex_wdata_i,
        input  logic                      mem_wreg_i,
        input  logic [`TM_REG_ADDR_W-1:0] mem_wd_i,
        input  logic [`TM_DATA_W-1:0]     mem_wdata_i,
        decode_bus_if.src                 dec,
        output logic [`TM_DATA_W-1:0]     ex_pc_o
);

        alu_op_e                   op;
        logic                      supported;
        logic                      use_imm;
        logic [`TM_REG_ADDR_W-1:0] dest;
        logic [`TM_DATA_W-1:0]     imm_zext;
        logic [`TM_DATA_W-1:0]     imm_sext;

        // newest producer wins
        function automatic logic [`TM_DATA_W-1:0] fwd_sel(
                input logic [`TM_REG_ADDR_W-1:0] addr,
                input logic [`TM_DATA_W-1:0]     rf_data
        );
                if (ex_wreg_i && ex_wd_i == addr)
                        return ex_wdata_i;
                else if (mem_wreg_i && mem_wd_i == addr)
                        return mem_wdata_i;
                else
                        return rf_data;
        endfunction

        assign imm_zext = {{(`TM_DATA_W-16){1'b0}}, id_inst_i.i.imm16};
        assign imm_sext = {{(`TM_DATA_W-16){id_inst_i.i.imm16[15]}}, id_inst_i.i.imm16};

        always_comb
        begin
                op        = ALU_NOP;
                supported = 1'b1;
                use_imm   = 1'b1;
                dest      = id_inst_i.i.rt;
                case (id_inst_i.r.opcode)
                        OP_SPECIAL:
                        begin
                                use_imm = 1'b0;
                                dest    = id_inst_i.r.rd;
                                case (id_inst_i.r.funct)
                                        F_ADDU:  op = ALU_ADDU;
                                        F_SUBU:  op = ALU_SUBU;
                                        F_AND:   op = ALU_AND;
                                        F_OR:    op = ALU_OR;
                                        F_XOR:   op = ALU_XOR;
                                        F_NOR:   op = ALU_NOR;
                                        F_SLT:   op = ALU_SLT;
                                        F_SLTU:  op = ALU_SLTU;
                                        default: supported = 1'b0;
                                endcase
                        end
                        OP_ADDIU: op = ALU_ADDU;
                        OP_SLTI:  op = ALU_SLT;
                        OP_ANDI:  op = ALU_AND;
                        OP_ORI:   op = ALU_OR;
                        OP_XORI:  op = ALU_XOR;
                        OP_LUI:   op = ALU_LUI;
                        default:  supported = 1'b0;
                endcase
        end

        assign reg1_addr_o = id_inst_i.r.rs;
        assign reg2_addr_o = id_inst_i.r.rt;

        always_comb
        begin
                dec.aluop  = op;
                dec.opnd_a = fwd_sel(id_inst_i.r.rs, reg1_data_i);
                // arithmetic and slti sign-extend, logic ops zero-extend
                if (!use_imm)
                        dec.opnd_b = fwd_sel(id_inst_i.r.rt, reg2_data_i);
                else if (op == ALU_ADDU || op == ALU_SLT)
                        dec.opnd_b = imm_sext;
                else
                        dec.opnd_b = imm_zext;
                dec.wd   = dest;
                dec.wreg = supported && (dest != '0);
        end

        assign ex_pc_o = id_pc_i;

endmodule

//--- design/regfile.sv
// r0 reads zero; a read of the register being written returns the new data
`timescale 1ns/1ps
`include "tinymips_config.svh"

module regfile (
        input  logic                      clk,
        input  logic                      rst_n_i,
        input  logic                      we_i,
        input  logic [`TM_REG_ADDR_W-1:0] waddr_i,
        input  logic [`TM_DATA_W-1:0]     wdata_i,
        input  logic [`TM_REG_ADDR_W-1:0] raddr1_i,
        input  logic [`TM_REG_ADDR_W-1:0] raddr2_i,
        output logic [`TM_DATA_W-1:0]     rdata1_o,
        output logic [`TM_DATA_W-1:0]     rdata2_o
);

        logic [`TM_DATA_W-1:0] regs [`TM_REG_NUM];

        function automatic logic [`TM_DATA_W-1:0] read_port(
                input logic [`TM_REG_ADDR_W-1:0] raddr
        );
                if (raddr == '0)
                        return '0;
                else if (we_i && raddr == waddr_i)
                        return wdata_i;
                else
                        return regs[raddr];
        endfunction

        always_ff @(posedge clk)
        begin
                if (!rst_n_i)
                begin
                        for (int i = 0; i < `TM_REG_NUM; i++)
                                regs[i] <= '0;
                end
                else if (we_i)
                        regs[waddr_i] <= wdata_i;
        end

        // write-through for the instruction three slots behind
        always_comb
        begin
                rdata1_o = read_port(raddr1_i);
                rdata2_o = read_port(raddr2_i);
        end

        // decoder must drop writes to r0
        a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
                we_i |-> waddr_i != '0);

endmodule

//--- design/alu_stage.sv
// ID/EX register and ALU; no overflow traps, ADDU and SUBU wrap
`timescale 1ns/1ps
`include "tinymips_config.svh"

module alu_stage import tinymips_pkg::*; (
        input  logic                      clk,
        input  logic                      rst_n_i,
        decode_bus_if.dst                 dec,
        input  logic [`TM_DATA_W-1:0]     pc_i,
        output logic                      ex_wreg_o,
        output logic [`TM_REG_ADDR_W-1:0] ex_wd_o,
        output logic [`TM_DATA_W-1:0]     ex_wdata_o,
        output logic [`TM_DATA_W-1:0]     ex_pc_o
);

        alu_op_e                   aluop_q;
        logic [`TM_DATA_W-1:0]     a_q;
        logic [`TM_DATA_W-1:0]     b_q;
        logic [`TM_REG_ADDR_W-1:0] wd_q;
        logic                      wreg_q;
        logic [`TM_DATA_W-1:0]     pc_q;

        always_ff @(posedge clk)
        begin
                if (!rst_n_i)
                        wreg_q <= 1'b0;
                else
                        wreg_q <= dec.wreg;
        end

        always_ff @(posedge clk)
        begin
                aluop_q <= dec.aluop;
                a_q     <= dec.opnd_a;
                b_q     <= dec.opnd_b;
                wd_q    <= dec.wd;
                pc_q    <= pc_i;
        end

        always_comb
        begin
                case (aluop_q)
                        ALU_ADDU: ex_wdata_o = a_q + b_q;
                        ALU_SUBU: ex_wdata_o = a_q - b_q;
                        ALU_AND:  ex_wdata_o = a_q & b_q;
                        ALU_OR:   ex_wdata_o = a_q | b_q;
                        ALU_XOR:  ex_wdata_o = a_q ^ b_q;
                        ALU_NOR:  ex_wdata_o = ~(a_q | b_q);
                        ALU_SLT:  ex_wdata_o = {{(`TM_DATA_W-1){1'b0}}, $signed(a_q) < $signed(b_q)};
                        ALU_SLTU: ex_wdata_o = {{(`TM_DATA_W-1){1'b0}}, a_q < b_q};
                        // immediate into the upper half
                        ALU_LUI:  ex_wdata_o = {b_q[15:0], {(`TM_DATA_W-16){1'b0}}};
                        default:  ex_wdata_o = '0;
                endcase
        end

        assign ex_wreg_o = wreg_q;
        assign ex_wd_o   = wd_q;
        assign ex_pc_o   = pc_q;

endmodule

//--- design/retire_stage.sv
// EX/MEM and MEM/WB; the memory stage passes results through unchanged
`timescale 1ns/1ps
`include "tinymips_config.svh"

module retire_stage (
        input  logic                      clk,
        input  logic                      rst_n_i,
        input  logic                      ex_wreg_i,
        input  logic [`TM_REG_ADDR_W-1:0] ex_wd_i,
        input  logic [`TM_DATA_W-1:0]     ex_wdata_i,
        input  logic [`TM_DATA_W-1:0]     ex_pc_i,
        output logic                      mem_wreg_o,
        output logic [`TM_REG_ADDR_W-1:0] mem_wd_o,
        output logic [`TM_DATA_W-1:0]     mem_wdata_o,
        output logic                      wb_we_o,
        output logic [`TM_REG_ADDR_W-1:0] wb_waddr_o,
        output logic [`TM_DATA_W-1:0]     wb_wdata_o,
        output logic [`TM_DATA_W-1:0]     wb_pc_o
);

        logic [`TM_DATA_W-1:0] mem_pc_q;

        always_ff @(posedge clk)
        begin
                if (!rst_n_i)
                begin
                        mem_wreg_o <= 1'b0;
                        wb_we_o    <= 1'b0;
                end
                else
                begin
                        mem_wreg_o <= ex_wreg_i;
                        wb_we_o    <= mem_wreg_o;
                end
        end

        always_ff @(posedge clk)
        begin
                mem_wd_o    <= ex_wd_i;
                mem_wdata_o <= ex_wdata_i;
                mem_pc_q    <= ex_pc_i;
                wb_waddr_o  <= mem_wd_o;
                wb_wdata_o  <= mem_wdata_o;
                wb_pc_o     <= mem_pc_q;
        end

        // catches undriven operands anywhere upstream
        a_wb_data_known: assert property (@(posedge clk) disable iff (!rst_n_i)
                wb_we_o |-> !$isunknown(wb_wdata_o));

endmodule

//--- design/tinymips.sv
// top of the core; ROM is combinational, writeback shows on debug ports 4 edges after fetch
`timescale 1ns/1ps
`include "tinymips_config.svh"

module tinymips import tinymips_pkg::*; (
        input  logic                      clk,
        input  logic                      rst_n_i,
        input  logic [`TM_DATA_W-1:0]     rom_data_i,
        output logic [`TM_DATA_W-1:0]     rom_addr_o,
        output logic                      rom_ce_o,
        output logic [`TM_DATA_W-1:0]     debug_wb_pc_o,
        output logic                      debug_wb_rf_wen_o,
        output logic [`TM_REG_ADDR_W-1:0] debug_wb_rf_wnum_o,
        output logic [`TM_DATA_W-1:0]     debug_wb_rf_wdata_o
);

        instr_u                    id_inst;
        logic [`TM_DATA_W-1:0]     id_pc;
        logic [`TM_DATA_W-1:0]     dec_pc;
        logic [`TM_REG_ADDR_W-1:0] reg1_addr;
        logic [`TM_REG_ADDR_W-1:0] reg2_addr;
        logic [`TM_DATA_W-1:0]     reg1_data;
        logic [`TM_DATA_W-1:0]     reg2_data;
        logic                      ex_wreg;
        logic [`TM_REG_ADDR_W-1:0] ex_wd;
        logic [`TM_DATA_W-1:0]     ex_wdata;
        logic [`TM_DATA_W-1:0]     ex_pc;
        logic                      mem_wreg;
        logic [`TM_REG_ADDR_W-1:0] mem_wd;
        logic [`TM_DATA_W-1:0]     mem_wdata;
        logic                      wb_we;
        logic [`TM_REG_ADDR_W-1:0] wb_waddr;
        logic [`TM_DATA_W-1:0]     wb_wdata;
        logic [`TM_DATA_W-1:0]     wb_pc;

        decode_bus_if dec_bus ();

        fetch_unit u_fetch (
                .clk(clk), .rst_n_i(rst_n_i),
                .rom_data_i(rom_data_i), .rom_addr_o(rom_addr_o), .rom_ce_o(rom_ce_o),
                .id_inst_o(id_inst), .id_pc_o(id_pc)
        );

        decoder u_decoder (
                .id_inst_i(id_inst), .id_pc_i(id_pc),
                .reg1_addr_o(reg1_addr), .reg2_addr_o(reg2_addr),
                .reg1_data_i(reg1_data), .reg2_data_i(reg2_data),
                .ex_wreg_i(ex_wreg), .ex_wd_i(ex_wd), .ex_wdata_i(ex_wdata),
                .mem_wreg_i(mem_wreg), .mem_wd_i(mem_wd), .mem_wdata_i(mem_wdata),
                .dec(dec_bus.src), .ex_pc_o(dec_pc)
        );

        regfile u_regfile (
                .clk(clk), .rst_n_i(rst_n_i),
                .we_i(wb_we), .waddr_i(wb_waddr), .wdata_i(wb_wdata),
                .raddr1_i(reg1_addr), .raddr2_i(reg2_addr),
                .rdata1_o(reg1_data), .rdata2_o(reg2_data)
        );

        alu_stage u_alu (
                .clk(clk), .rst_n_i(rst_n_i),
                .dec(dec_bus.dst), .pc_i(dec_pc),
                .ex_wreg_o(ex_wreg), .ex_wd_o(ex_wd), .ex_wdata_o(ex_wdata),
                .ex_pc_o(ex_pc)
        );

        retire_stage u_retire (
                .clk(clk), .rst_n_i(rst_n_i),
                .ex_wreg_i(ex_wreg), .ex_wd_i(ex_wd), .ex_wdata_i(ex_wdata),
                .ex_pc_i(ex_pc),
                .mem_wreg_o(mem_wreg), .mem_wd_o(mem_wd), .mem_wdata_o(mem_wdata),
                .wb_we_o(wb_we), .wb_waddr_o(wb_waddr), .wb_wdata_o(wb_wdata),
                .wb_pc_o(wb_pc)
        );

        // debug view of the writeback port
        assign debug_wb_pc_o       = wb_pc;
        assign debug_wb_rf_wen_o   = wb_we;
        assign debug_wb_rf_wnum_o  = wb_waddr;
        assign debug_wb_rf_wdata_o = wb_wdata;

endmodule

//--- tests/tb_tinymips.sv
// reads tests/tinymips_cases.txt from the run directory; the ROM model holds at most 64 cases
`timescale 1ns/1ps
`include "tinymips_config.svh"

module tb_tinymips import tinymips_pkg::*; ();

        localparam int CLK_PERIOD = 20;
        localparam int MAX_CASES  = 64;
        localparam int NAME_W     = 8 * 24;

        logic                      clk;
        logic                      rst_n;
        logic [`TM_DATA_W-1:0]     rom_data;
        logic [`TM_DATA_W-1:0]     rom_addr;
        logic                      rom_ce;
        logic [`TM_DATA_W-1:0]     dbg_pc;
        logic                      dbg_wen;
        logic [`TM_REG_ADDR_W-1:0] dbg_wnum;
        logic [`TM_DATA_W-1:0]     dbg_wdata;

        logic [NAME_W-1:0]         case_name [MAX_CASES];
        instr_u                    case_word [MAX_CASES];
        logic                      case_writes [MAX_CASES];
        logic [`TM_REG_ADDR_W-1:0] case_dest [MAX_CASES];
        logic [`TM_DATA_W-1:0]     case_value [MAX_CASES];

        int num_cases    = 0;
        int retired      = 0;
        int pass_count   = 0;
        int fail_count   = 0;
        bit cases_loaded = 1'b0;

        tinymips UUT (
                .clk(clk), .rst_n_i(rst_n),
                .rom_data_i(rom_data), .rom_addr_o(rom_addr), .rom_ce_o(rom_ce),
                .debug_wb_pc_o(dbg_pc), .debug_wb_rf_wen_o(dbg_wen),
                .debug_wb_rf_wnum_o(dbg_wnum), .debug_wb_rf_wdata_o(dbg_wdata)
        );

        initial
        begin
                clk = 1'b0;
                forever #(CLK_PERIOD / 2) clk = ~clk;
        end

        // lines are: name word dest value, or name word none
        task automatic load_cases();
                int                    fd;
                int                    n;
                int                    ch;
                int                    dnum;
                logic [NAME_W-1:0]     tok;
                logic [NAME_W-1:0]     dst_tok;
                logic [`TM_DATA_W-1:0] word;
                logic [`TM_DATA_W-1:0] value;
                fd = $fopen("tests/tinymips_cases.txt", "r");
                if (fd == 0)
                begin
                        $display("cannot open tests/tinymips_cases.txt");
                        fail_count++;
                end
                else
                begin
                        n = $fscanf(fd, "%s", tok);
                        while (n == 1 && num_cases < MAX_CASES)
                        begin
                                if (tok == NAME_W'("#"))
                                begin
                                        // skip the rest of a comment line
                                        ch = $fgetc(fd);
                                        while (ch != 10 && ch != -1)
                                                ch = $fgetc(fd);
                                end
                                else
                                begin
                                        n = $fscanf(fd, "%h %s", word, dst_tok);
                                        case_name[num_cases]   = tok;
                                        case_word[num_cases]   = word;
                                        case_writes[num_cases] = 1'b0;
                                        case_dest[num_cases]   = '0;
                                        case_value[num_cases]  = '0;
                                        if (dst_tok != NAME_W'("none"))
                                        begin
                                                n = $sscanf(dst_tok, "%d", dnum);
                                                n = $fscanf(fd, "%h", value);
                                                case_writes[num_cases] = 1'b1;
                                                case_dest[num_cases]   = dnum[4:0];
                                                case_value[num_cases]  = value;
                                        end
                                        num_cases++;
                                end
                                n = $fscanf(fd, "%s", tok);
                        end
                        $fclose(fd);
                end
        endtask

        // zero beyond the last case and while fetch is off
        function automatic logic [`TM_DATA_W-1:0] rom_word(
                input logic [`TM_DATA_W-1:0] addr,
                input logic                  ce
        );
                logic [`TM_DATA_W-1:0] slot;
                slot = (addr - `TM_RESET_PC) / `TM_PC_STEP;
                if (!ce || slot >= 32'(num_cases))
                        return '0;
                else
                        return case_word[int'(slot)];
        endfunction

        task automatic report_test(input string name, input bit ok);
                if (ok)
                begin
                        pass_count++;
                        $display("PASS %0s", name);
                end
                else
                        fail_count++;
        endtask

        task automatic check_case(input int idx);
                logic [`TM_DATA_W-1:0] exp_pc;
                bit                    ok;
                exp_pc = `TM_RESET_PC + `TM_PC_STEP * 32'(idx);
                ok     = 1'b1;
                assert (dbg_pc == exp_pc)
                else
                begin
                        $display("FAIL %0s: expected pc %h, actual pc %h",
                                 case_name[idx], exp_pc, dbg_pc);
                        ok = 1'b0;
                end
                if (case_writes[idx])
                begin
                        assert (dbg_wen && dbg_wnum == case_dest[idx] &&
                                dbg_wdata == case_value[idx])
                        else
                        begin
                                $display("FAIL %0s: expected r%0d = %h, actual wen %b r%0d = %h",
                                         case_name[idx], case_dest[idx], case_value[idx],
                                         dbg_wen, dbg_wnum, dbg_wdata);
                                ok = 1'b0;
                        end
                end
                else
                begin
                        assert (!dbg_wen)
                        else
                        begin
                                $display("FAIL %0s: expected no writeback, actual r%0d = %h",
                                         case_name[idx], dbg_wnum, dbg_wdata);
                                ok = 1'b0;
                        end
                end
                retired++;
                if (ok)
                begin
                        pass_count++;
                        $display("PASS %0s: pc %h opcode %h", case_name[idx], exp_pc,
                                 case_word[idx].r.opcode);
                end
                else
                        fail_count++;
        endtask

        initial
        begin
                int                    cycle;
                bit                    reset_ok;
                bit                    fill_ok;
                bit                    fetch_ok;
                logic [`TM_DATA_W-1:0] exp_addr;
                rst_n    = 1'b0;
                rom_data = '0;
                load_cases();
                cases_loaded = 1'b1;
                reset_ok = 1'b1;
                fill_ok  = 1'b1;
                fetch_ok = 1'b1;

                repeat (3)
                begin
                        @(negedge clk);
                        assert (!rom_ce && !dbg_wen)
                        else
                        begin
                                $display("FAIL reset: expected rom_ce 0 wen 0, actual %b %b",
                                         rom_ce, dbg_wen);
                                reset_ok = 1'b0;
                        end
                end
                rst_n = 1'b1;
                report_test("reset", reset_ok);

                // cycle k fetches case k, which retires at cycle k + 4
                cycle = 0;
                while (cycle < num_cases + 4)
                begin
                        @(negedge clk);
                        exp_addr = `TM_RESET_PC + `TM_PC_STEP * 32'(cycle);
                        assert (rom_ce && rom_addr == exp_addr)
                        else
                        begin
                                $display("FAIL fetch_order: expected address %h, actual %h ce %b",
                                         exp_addr, rom_addr, rom_ce);
                                fetch_ok = 1'b0;
                        end
                        rom_data = rom_word(rom_addr, rom_ce);
                        if (cycle < 4)
                        begin
                                assert (!dbg_wen)
                                else
                                begin
                                        $display("FAIL pipeline_fill: expected wen 0, actual %b",
                                                 dbg_wen);
                                        fill_ok = 1'b0;
                                end
                                if (cycle == 3)
                                        report_test("pipeline_fill", fill_ok);
                        end
                        else
                                check_case(cycle - 4);
                        cycle++;
                end
                report_test("fetch_order", fetch_ok);

                $display("%0d tests passed, %0d failed, %0d of %0d cases retired",
                         pass_count, fail_count, retired, num_cases);
                if (fail_count == 0 && num_cases > 0)
                        $display("Finished with no errors");
                else
                        $display("Finished with errors");
                $finish;
        end

        // watchdog, sized from the number of cases
        initial
        begin
                wait (cases_loaded);
                #(2 * (num_cases + 10) * CLK_PERIOD);
                $display("timeout: the run hung after %0d of %0d cases retired",
                         retired, num_cases);
                $display("Finished with errors");
                $finish;
        end

endmodule

//--- tests/tinymips_cases.txt
# name  instruction word (hex)  dest register (decimal) or none  expected value (hex)
# cases run in file order from the reset PC, one instruction each
lui_r1          3c018000  1     80000000
ori_zext        3402f0f0  2     0000f0f0
addiu_sext      2403fffe  3     fffffffe
addu_fwd_ex_mem 00622021  4     0000f0ee
subu_wrap       00242823  5     7fff0f12
slt_signed_wt   0062302a  6     00000001
sltu_unsigned   0062382b  7     00000000
and_wt          00a24024  8     00000010
or_fwd_ex       01014825  9     80000010
xor_fwd_ex      01255026  10    ffff0f02
nor_fwd_wt      01485827  11    0000f0ed
slti_sext_mem   294c8000  12    00000001
andi_zext_mem   316dff0f  13    0000f00d
xori_zext_ex    39ae8000  14    0000700d
addiu_to_r0     24200055  none
load_unsupp     8c010000  none
addu_r0_read    00017821  15    80000000
sltu_true       0043802b  16    00000001

//--- tinymips.f
+incdir+include
design/tinymips_pkg.sv
design/decode_bus_if.sv
design/fetch_unit.sv
design/decoder.sv
design/regfile.sv
design/alu_stage.sv
design/retire_stage.sv
design/tinymips.sv
tests/tb_tinymips.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_tinymips -f tinymips.f -o sim_tinymips
./obj_dir/sim_tinymips > sim.log 2>&1 || true
cat sim.log

if grep -qx "Finished with no errors" sim.log
then
        echo "simulation passed"
else
        echo "simulation failed"
        exit 1
fi
